/* branchResolve.f */
+incdir+.
branchPkg.sv
branchDecoder.sv
branchUnit.sv
branchSelector.sv
branchResolve.sv
branchResolveTb.sv

/* Makefile */
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module branchResolveTb \
		-f branchResolve.f -o simv

run: compile
	./obj_dir/simv

clean:
	rm -rf obj_dir

/* branchResolveModel.svh */
`ifndef BRANCH_RESOLVE_MODEL_SVH
`define BRANCH_RESOLVE_MODEL_SVH

BranchProv laneReg[NUM_LANES];     // Lane redirects as the units hold them after an edge.
SqN modelFlushSqN;

function automatic bit olderModel(SqN a, SqN b);
    SqN d;
    d = a - b;
    return d[6];                   // A negative 7-bit difference means a is older.
endfunction

function automatic void resolveModel(input IssueUop u, output bit isCtl, output bit cond,
                                     output logic [31:0] tgt);
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    w = u.instr;
    a = u.rs1Val;
    b = u.rs2Val;
    isCtl = 1'b1;
    cond = 1'b1;
    tgt = u.pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    case (w[6:0])
        7'b1100011: begin
            case (w[14:12])
                3'd0: cond = a == b;
                3'd1: cond = a != b;
                3'd4: cond = $signed(a) < $signed(b);
                3'd5: cond = $signed(a) >= $signed(b);
                3'd6: cond = a < b;
                3'd7: cond = a >= b;
                default: isCtl = 1'b0;
            endcase
        end
        7'b1101111: tgt = u.pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        7'b1100111: begin
            isCtl = w[14:12] == 3'd0;
            tgt = a + {{20{w[31]}}, w[31:20]};
            tgt[0] = 1'b0;
        end
        default: isCtl = 1'b0;
    endcase
endfunction

function automatic BranchProv laneModel(IssueUop u);
    BranchProv p;
    bit isCtl;
    bit cond;
    logic [31:0] tgt;
    resolveModel(u, isCtl, cond, tgt);
    p = '0;
    p.taken = u.valid && isCtl && (cond != u.predTaken || (cond && tgt != u.predTarget));
    p.dstPC = cond ? tgt : u.pc + 32'd4;
    p.sqN = u.sqN;
    p.loadSqN = u.loadSqN;
    p.storeSqN = u.storeSqN;
    p.fetchID = u.fetchID;
    p.histAct = u.histAct;
    p.retAct = u.retAct;
    return p;
endfunction

function automatic BranchProv selectModel(BranchProv com, bit flushHeld, output bit perf);
    BranchProv best;
    best = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
        if (laneReg[i].taken && (!best.taken || olderModel(laneReg[i].sqN, best.sqN)) &&
            (!flushHeld || olderModel(laneReg[i].sqN, modelFlushSqN))) begin
            best = laneReg[i];
        end
    end
    perf = best.taken && !flushHeld && !com.taken;
    if (com.taken && (!flushHeld || olderModel(com.sqN, modelFlushSqN))) begin
        best = com;                // Commit overrides every lane.
    end
    return best;
endfunction

`endif

/* branchResolveTb.sv */
`timescale 1ns/1ps

module branchResolveTb;
    import branchPkg::*;

    localparam int NUM_LANES = 3;
    localparam int CYCLES = 4000;
    localparam int TIMEOUT = 20;

    logic clk;
    logic rst;
    IssueUop issue[NUM_LANES-1:0];
    BranchProv commitBranch;
    SqN robSqN;
    SqN nextSqN;
    logic mispredFlush;
    BranchProv branch;
    logic perfBranchMispr;

    string testName;
    SqN windowBase;                // Models robSqN; nextSqN sits 48 above it.
    IssueUop driven[NUM_LANES];
    BranchProv commitExp;
    bit flushExp;
    bit found;
    int waited;

    `include "branchResolveModel.svh"

    branchResolve #(
        .NUM_LANES(NUM_LANES)
    ) u_dut (
        .clk(clk),
        .rst(rst),
        .issue(issue),
        .commitBranch(commitBranch),
        .robSqN(robSqN),
        .nextSqN(nextSqN),
        .mispredFlush(mispredFlush),
        .branch(branch),
        .perfBranchMispr(perfBranchMispr)
    );

    always #50 clk = ~clk;

    task automatic checkProv(BranchProv exp, BranchProv act);
        if (exp !== act) begin
            $display("error %s: expected %h actual %h", testName, exp, act);
            $display("** FAIL **");
            $fatal(1, "redirect mismatch");
        end
    endtask

    task automatic checkPerf(bit exp, logic act);
        if (exp !== act) begin
            $display("error %s: expected %b actual %b", testName, exp, act);
            $display("** FAIL **");
            $fatal(1, "mispredict event mismatch");
        end
    endtask

    function automatic IssueUop randomUop(SqN sqN, bit forceMiss);
        IssueUop u;
        logic [31:0] w;
        bit isCtl;
        bit cond;
        logic [31:0] tgt;
        int kind;
        kind = $urandom % 10;
        w = $urandom;
        if (kind < 6) begin
            w[6:0] = 7'b1100011;
        end else if (kind < 8) begin
            w[6:0] = 7'b1101111;
        end else if (kind == 8) begin
            w[6:0] = 7'b1100111;
            if (($urandom % 4) != 0) begin
                w[14:12] = 3'd0;
            end
        end else if (w[6:0] inside {7'b1100011, 7'b1101111, 7'b1100111}) begin
            w[6:0] = 7'b0010011;   // Plain ALU word.
        end
        u = '0;
        u.valid = ($urandom % 8) != 0;
        u.instr = InstrWord'(w);
        u.pc = $urandom & 32'hfffffffc;
        u.rs1Val = $urandom;
        u.rs2Val = (($urandom % 3) == 0) ? u.rs1Val : $urandom;
        u.sqN = sqN;
        u.loadSqN = LoadSqN'($urandom);
        u.storeSqN = StoreSqN'($urandom);
        u.fetchID = FetchID'($urandom);
        u.histAct = HistAct'($urandom);
        u.retAct = RetAct'($urandom);
        resolveModel(u, isCtl, cond, tgt);
        u.predTaken = cond;
        u.predTarget = cond ? tgt : $urandom;
        if (forceMiss || ($urandom % 2) == 1) begin
            if (cond && ($urandom % 2) == 1) begin
                u.predTarget = tgt ^ 32'h10;
            end else begin
                u.predTaken = !cond;
            end
        end
        return u;
    endfunction

    // Mode 0 idles, mode 1 forces mispredictions, mode 2 is fully random.
    task automatic runCycle(int mode);
        SqN start;
        int rot;
        bit perfExp;
        BranchProv exp;
        @(posedge clk);
        for (int i = 0; i < NUM_LANES; i++) begin
            laneReg[i] = laneModel(driven[i]);
        end
        if (mode == 2 && ($urandom % 2) == 1) begin
            windowBase = windowBase + 7'd1;
        end
        start = windowBase + SqN'(4 + $urandom % 30);
        rot = $urandom % NUM_LANES;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (mode == 0) begin
                driven[i] = '0;
            end else begin
                driven[i] = randomUop(start + SqN'((i + rot) % NUM_LANES), mode == 1);
            end
            issue[i] <= driven[i];
        end
        commitExp = '0;
        if (mode == 2 && ($urandom % 8) == 0) begin
            commitExp.taken = 1'b1;
            commitExp.flush = ($urandom % 2) == 1;
            commitExp.dstPC = $urandom & 32'hfffffffc;
            commitExp.sqN = windowBase + SqN'(4 + $urandom % 30);
            commitExp.loadSqN = LoadSqN'($urandom);
            commitExp.fetchID = FetchID'($urandom);
        end
        if (mode != 2) begin
            flushExp = 1'b0;
        end else if (($urandom % 16) == 0) begin
            flushExp = !flushExp;  // Flush is held for long stretches.
        end
        commitBranch <= commitExp;
        mispredFlush <= flushExp;
        robSqN <= windowBase;
        nextSqN <= windowBase + 7'd48;
        @(negedge clk);
        exp = selectModel(commitExp, flushExp, perfExp);
        checkProv(exp, branch);
        checkPerf(perfExp, perfBranchMispr);
        if (exp.taken) begin
            modelFlushSqN = exp.sqN;
        end
    endtask

    initial begin
        void'($urandom(76));
        clk = 1'b0;
        rst <= 1'b1;
        windowBase = SqN'($urandom);
        for (int i = 0; i < NUM_LANES; i++) begin
            issue[i] <= '0;
            driven[i] = '0;
            laneReg[i] = '0;
        end
        commitBranch <= '0;
        robSqN <= windowBase;
        nextSqN <= windowBase + 7'd48;
        mispredFlush <= 1'b0;
        flushExp = 1'b0;
        modelFlushSqN = '0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        testName = "idle";
        repeat (5) runCycle(0);

        testName = "firstRedirect";
        found = 1'b0;
        waited = 0;
        while (!found) begin
            if (waited == TIMEOUT) begin
                $display("** FAIL **");
                $fatal(1, "no redirect appeared after forced mispredictions");
            end
            runCycle(1);
            found = branch.taken;
            waited++;
        end

        testName = "random";
        for (int n = 0; n < CYCLES; n++) begin
            runCycle(2);
        end
        $display("** PASS **");
        $finish;
    end

endmodule

/* branchResolve.sv */
`timescale 1ns/1ps

module branchResolve #(
    parameter int NUM_LANES = 3
) (
    input logic clk,
    input logic rst,
    input branchPkg::IssueUop issue[NUM_LANES-1:0],
    input branchPkg::BranchProv commitBranch,
    input branchPkg::SqN robSqN,
    input branchPkg::SqN nextSqN,
    input logic mispredFlush,
    output branchPkg::BranchProv branch,
    output logic perfBranchMispr
);
    import branchPkg::*;

    localparam int NUM_BRANCHES = NUM_LANES + 1;

    BranchOp laneOp[NUM_LANES-1:0];
    logic [31:0] laneImm[NUM_LANES-1:0];
    BranchProv prov[NUM_BRANCHES-1:0];

    for (genvar i = 0; i < NUM_LANES; i++) begin : gLane
        branchDecoder uDecoder (
            .instr(issue[i].instr),
            .op(laneOp[i]),
            .imm(laneImm[i])
        );

        branchUnit uUnit (
            .clk(clk),
            .rst(rst),
            .uop(issue[i]),
            .op(laneOp[i]),
            .imm(laneImm[i]),
            .prov(prov[i])
        );
    end

    assign prov[NUM_LANES] = commitBranch;  // Commit takes the highest-priority slot.

    branchSelector #(
        .NUM_BRANCHES(NUM_BRANCHES)
    ) uSelector (
        .clk(clk),
        .rst(rst),
        .branches(prov),
        .branch(branch),
        .perfBranchMispr(perfBranchMispr),
        .robSqN(robSqN),
        .nextSqN(nextSqN),
        .mispredFlush(mispredFlush)
    );

endmodule

/* branchSelector.sv */
`timescale 1ns/1ps

module branchSelector #(
    parameter int NUM_BRANCHES = 4
) (
    input logic clk,
    input logic rst,
    input branchPkg::BranchProv branches[NUM_BRANCHES-1:0],
    output branchPkg::BranchProv branch,
    output logic perfBranchMispr,
    input branchPkg::SqN robSqN,
    input branchPkg::SqN nextSqN,
    input logic mispredFlush
);
    import branchPkg::*;

    SqN flushSqN;                  // Last forwarded redirect.
    BranchProv laneBest;
    BranchProv commit;
    logic commitPass;

    always_comb begin
        laneBest = '0;
        for (int i = 0; i < NUM_BRANCHES - 1; i++) begin
            if (branches[i].taken &&
                (!laneBest.taken || isOlder(branches[i].sqN, laneBest.sqN)) &&
                (!mispredFlush || isOlder(branches[i].sqN, flushSqN))) begin
                laneBest = branches[i];
            end
        end
    end

    assign commit = branches[NUM_BRANCHES-1];
    assign commitPass = commit.taken && (!mispredFlush || isOlder(commit.sqN, flushSqN));

    always_comb begin
        if (commitPass) begin
            branch = commit;
        end else begin
            branch = laneBest;
        end
    end

    assign perfBranchMispr = laneBest.taken && !mispredFlush && !commit.taken;

    always_ff @(posedge clk) begin
        if (rst) begin
            flushSqN <= '0;
        end else if (branch.taken) begin
            flushSqN <= branch.sqN;
        end
    end

    // Every redirect must name an instruction that is still in flight.
    sqNInWindow: assert property (
        @(posedge clk) disable iff (rst)
        branch.taken |-> !isOlder(branch.sqN, robSqN) && isOlder(branch.sqN, nextSqN)
    ) else $error("redirect sqN outside the reorder-buffer window");

    perfOnLaneRedirect: assert property (
        @(posedge clk) disable iff (rst)
        perfBranchMispr |-> branch.taken && !branch.flush
    ) else $error("mispredict event without a lane redirect");

endmodule

/* branchUnit.sv */
`timescale 1ns/1ps

module branchUnit (
    input logic clk,
    input logic rst,
    input branchPkg::IssueUop uop,
    input branchPkg::BranchOp op,
    input logic [31:0] imm,
    output branchPkg::BranchProv prov
);
    import branchPkg::*;

    logic condTaken;
    logic [31:0] jalrSum;
    logic [31:0] target;
    logic [31:0] nextPC;
    logic mispred;
    BranchProv provNext;

    always_comb begin
        case (op)
            brBeq: condTaken = (uop.rs1Val == uop.rs2Val);
            brBne: condTaken = (uop.rs1Val != uop.rs2Val);
            brBlt: condTaken = ($signed(uop.rs1Val) < $signed(uop.rs2Val));
            brBge: condTaken = ($signed(uop.rs1Val) >= $signed(uop.rs2Val));
            brBltu: condTaken = (uop.rs1Val < uop.rs2Val);
            brBgeu: condTaken = (uop.rs1Val >= uop.rs2Val);
            brJal, brJalr: condTaken = 1'b1;
            default: condTaken = 1'b0;
        endcase
    end

    assign jalrSum = uop.rs1Val + imm;

    always_comb begin
        if (op == brJalr) begin
            target = {jalrSum[31:1], 1'b0};  // Jalr clears bit 0 of the sum.
        end else begin
            target = uop.pc + imm;
        end
    end

    assign nextPC = condTaken ? target : uop.pc + 32'd4;

    // A correct direction with a wrong target still needs a redirect.
    assign mispred = (condTaken != uop.predTaken) ||
                     (condTaken && (target != uop.predTarget));

    always_comb begin
        provNext.taken = uop.valid && (op != brNone) && mispred;
        provNext.flush = 1'b0;
        provNext.dstPC = nextPC;
        provNext.sqN = uop.sqN;
        provNext.loadSqN = uop.loadSqN;
        provNext.storeSqN = uop.storeSqN;
        provNext.fetchID = uop.fetchID;
        provNext.histAct = uop.histAct;
        provNext.retAct = uop.retAct;
    end

    always_ff @(posedge clk) begin
        prov <= provNext;
        if (rst) begin
            prov.taken <= 1'b0;
            prov.flush <= 1'b0;
        end
    end

    // A lane redirect never flushes and always lands on an even address.
    provNoFlushAligned: assert property (
        @(posedge clk) disable iff (rst)
        prov.taken |-> !prov.flush && !prov.dstPC[0]
    ) else $error("lane redirect with flush set or an odd target");

endmodule

/* branchDecoder.sv */
`timescale 1ns/1ps

module branchDecoder (
    input branchPkg::InstrWord instr,
    output branchPkg::BranchOp op,
    output logic [31:0] imm
);
    import branchPkg::*;

    logic [31:0] bImm;
    logic [31:0] jImm;
    logic [31:0] iImm;

    // Conditional branches use halfword offsets with an implied zero in bit 0.
    assign bImm = {
        {20{instr.bType.imm12}},
        instr.bType.imm11,
        instr.bType.immHi,
        instr.bType.immLo,
        1'b0
    };

    assign jImm = {
        {12{instr.jType.imm20}},
        instr.jType.immHi,
        instr.jType.imm11,
        instr.jType.immLo,
        1'b0
    };

    // The jalr offset is a plain byte offset taken from the top twelve bits.
    assign iImm = {
        {20{instr.bType.imm12}},
        instr.bType.imm12,
        instr.bType.immHi,
        instr.bType.rs2
    };

    always_comb begin
        op = brNone;
        imm = '0;
        case (instr.bType.opcode)
            OPC_BRANCH: begin
                imm = bImm;
                case (instr.bType.funct3)
                    3'b000: op = brBeq;
                    3'b001: op = brBne;
                    3'b100: op = brBlt;
                    3'b101: op = brBge;
                    3'b110: op = brBltu;
                    3'b111: op = brBgeu;
                    default: op = brNone;  // Encodings 010 and 011 are reserved.
                endcase
            end
            OPC_JAL: begin
                imm = jImm;
                op = brJal;
            end
            OPC_JALR: begin
                imm = iImm;
                if (instr.bType.funct3 == 3'b000) begin
                    op = brJalr;
                end
            end
            default: begin
                op = brNone;
                imm = '0;
            end
        endcase
    end

endmodule

/* branchPkg.sv */
package branchPkg;

    typedef logic [6:0] SqN;       // Wraps around, so age comes from the signed difference.
    typedef logic [4:0] FetchID;
    typedef logic [5:0] LoadSqN;
    typedef logic [5:0] StoreSqN;
    typedef logic [1:0] HistAct;
    typedef logic [1:0] RetAct;

    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL = 7'b1101111;
    localparam logic [6:0] OPC_JALR = 7'b1100111;

    typedef enum logic [3:0] {
        brNone = 4'd0,
        brBeq = 4'd1,
        brBne = 4'd2,
        brBlt = 4'd3,
        brBge = 4'd4,
        brBltu = 4'd5,
        brBgeu = 4'd6,
        brJal = 4'd7,
        brJalr = 4'd8
    } BranchOp;

    // B-type layout. The I-type immediate of jalr sits in imm12, immHi and rs2.
    typedef struct packed {
        logic imm12;
        logic [5:0] immHi;         // Offset bits 10 to 5.
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] immLo;         // Offset bits 4 to 1.
        logic imm11;
        logic [6:0] opcode;
    } BType;

    typedef struct packed {
        logic imm20;
        logic [9:0] immLo;         // Offset bits 10 to 1.
        logic imm11;
        logic [7:0] immHi;         // Offset bits 19 to 12.
        logic [4:0] rd;
        logic [6:0] opcode;
    } JType;

    typedef union packed {
        BType bType;
        JType jType;
    } InstrWord;

    typedef struct packed {
        logic valid;
        InstrWord instr;
        logic [31:0] pc;
        logic [31:0] rs1Val;
        logic [31:0] rs2Val;
        SqN sqN;
        LoadSqN loadSqN;
        StoreSqN storeSqN;
        FetchID fetchID;
        logic predTaken;
        logic [31:0] predTarget;
        HistAct histAct;
        RetAct retAct;
    } IssueUop;

    typedef struct packed {
        logic taken;
        logic flush;
        logic [31:0] dstPC;
        SqN sqN;
        LoadSqN loadSqN;
        StoreSqN storeSqN;
        FetchID fetchID;
        HistAct histAct;
        RetAct retAct;
    } BranchProv;

    function automatic logic isOlder(SqN a, SqN b);
        SqN diff;
        diff = a - b;
        return diff[6];            // Negative difference means a is older.
    endfunction

endpackage
